//--- common/coreinfo_consts.svh
// Widths and identifiers fixed at build time; the word index covers address bits 11:2 only
`ifndef COREINFO_CONSTS_SVH
`define COREINFO_CONSTS_SVH

// Master-side read ID width
`define AXI_ID_WIDTH 4

// Slave side carries one extra bit for the master index
`define SLV_ID_WIDTH (`AXI_ID_WIDTH + 1)

`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// Burst length field, beats minus one
`define LEN_WIDTH 4

// Word index taken from ARADDR[11:2]
`define WORD_BITS 10

// Identifier returned at word 0 for each master
`define CORE0_ID 32'hC0DE_0000
`define CORE1_ID 32'hC0DE_0001

// Number of cores reported at word 1
`define N_CORES 2

// Block version reported at word 2
`define COREINFO_VERSION 32'h0001_0200

`endif

//--- common/coreinfo_pkg.sv
// Shared types for the core-information read path; widths come from the constants header
`default_nettype none

`include "coreinfo_consts.svh"

package coreinfo_pkg;

	// Read ID as seen by one master
	typedef logic [`AXI_ID_WIDTH-1:0] mst_id_t;

	// Read ID on the merged slave port, master index on top
	typedef logic [`SLV_ID_WIDTH-1:0] slv_id_t;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DATA_WIDTH-1:0] data_t;

	// Beats minus one, INCR bursts up to 16 beats
	typedef logic [`LEN_WIDTH-1:0] len_t;

	// Word index into the register map
	typedef logic [`WORD_BITS-1:0] word_t;

	// Slave read sequencer states
	typedef enum logic [1:0] {
		RD_IDLE = 2'd0, // Waiting for an address
		RD_PREP = 2'd1, // One cycle to set up the first beat
		RD_DATA = 2'd2  // Returning beats
	} rd_state_t;

endpackage

`default_nettype wire

//--- coreinfo/beat_counter.sv
// Beat counter for bursts of up to 16 beats; length is captured once per burst
`timescale 1ns/100ps
`default_nettype none

module beat_counter import coreinfo_pkg::*; (
	input  logic clk_i,
	input  logic rst_n,
	input  logic load,
	input  logic advance,
	input  len_t ar_len,
	output len_t count,
	output logic last
);

	len_t len_q; // Beats minus one of the current burst

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			len_q <= '0;
			count <= '0;
		end else begin
			if (load) begin
				len_q <= ar_len;
				count <= '0; // Restart at the first beat
			end else if (advance) begin
				count <= count + len_t'(1);
			end
		end
	end

	assign last = (count == len_q);

endmodule

`default_nettype wire

//--- coreinfo/read_fsm.sv
// Read sequencer of the slave; one burst at a time with one setup cycle before the first beat
`timescale 1ns/100ps
`default_nettype none

module read_fsm import coreinfo_pkg::*; (
	input  logic clk_i,
	input  logic rst_n,
	input  logic ar_valid,
	input  logic r_ready,
	input  logic last,
	output logic ar_ready,
	output logic r_valid,
	output logic load,
	output logic advance
);

	rd_state_t state;
	rd_state_t state_nxt;
	logic      beat_fire;

	assign ar_ready  = (state == RD_IDLE);
	assign r_valid   = (state == RD_DATA);
	assign beat_fire = r_valid & r_ready;

	assign load    = ar_valid & ar_ready;
	assign advance = beat_fire & ~last; // Final beat ends the burst instead

	always_comb begin
		state_nxt = state;
		case (state)
			RD_IDLE: begin
				if (load) begin
					state_nxt = RD_PREP;
				end
			end
			RD_PREP: begin
				state_nxt = RD_DATA; // Map output settles here
			end
			RD_DATA: begin
				if (beat_fire && last) begin
					state_nxt = RD_IDLE;
				end
			end
			default: begin
				state_nxt = RD_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state <= RD_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

`default_nettype wire

//--- coreinfo/info_regs.sv
// Core-information register map; word index wraps within address bits 11:2
`timescale 1ns/100ps
`default_nettype none

`include "coreinfo_consts.svh"

module info_regs import coreinfo_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_n,
	input  logic    load,
	input  addr_t   ar_addr,
	input  slv_id_t ar_id,
	input  len_t    count,
	output data_t   r_data,
	output slv_id_t r_id
);

	word_t base_q;  // Start word of the burst
	data_t core_id; // Identifier of the requesting core
	word_t word_idx;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			base_q <= '0;
			r_id   <= '0;
		end else if (load) begin
			base_q <= ar_addr[11:2];
			r_id   <= ar_id;
		end
	end

	// Top ID bit is the master index from the arbiter
	always_ff @(posedge clk_i) begin
		if (load) begin
			core_id <= ar_id[$bits(slv_id_t)-1] ? `CORE1_ID : `CORE0_ID;
		end
	end

	assign word_idx = base_q + word_t'(count); // INCR steps one word per beat

	always_comb begin
		case (word_idx)
			word_t'(0): r_data = core_id;
			word_t'(1): r_data = data_t'(`N_CORES);
			word_t'(2): r_data = `COREINFO_VERSION;
			default:    r_data = '1; // Unmapped words
		endcase
	end

endmodule

`default_nettype wire

//--- coreinfo/coreinfo_slave.sv
// AXI4 read-only slave for the core-information map; INCR full-width bursts only, no writes
`timescale 1ns/100ps
`default_nettype none

module coreinfo_slave import coreinfo_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_n,

	input  logic    s_ar_valid,
	output logic    s_ar_ready,
	input  slv_id_t s_ar_id,
	input  addr_t   s_ar_addr,
	input  len_t    s_ar_len,

	output logic    s_r_valid,
	input  logic    s_r_ready,
	output data_t   s_r_data,
	output slv_id_t s_r_id,
	output logic    s_r_last
);

	logic load;    // Address accepted
	logic advance; // Non-final beat taken
	logic last;    // Current beat is the final one
	len_t count;   // Beat index within the burst

	read_fsm u_read_fsm (
		.clk_i    (clk_i),
		.rst_n    (rst_n),
		.ar_valid (s_ar_valid),
		.r_ready  (s_r_ready),
		.last     (last),
		.ar_ready (s_ar_ready),
		.r_valid  (s_r_valid),
		.load     (load),
		.advance  (advance)
	);

	beat_counter u_beat_counter (
		.clk_i   (clk_i),
		.rst_n   (rst_n),
		.load    (load),
		.advance (advance),
		.ar_len  (s_ar_len),
		.count   (count),
		.last    (last)
	);

	info_regs u_info_regs (
		.clk_i   (clk_i),
		.rst_n   (rst_n),
		.load    (load),
		.ar_addr (s_ar_addr),
		.ar_id   (s_ar_id),
		.count   (count),
		.r_data  (s_r_data),
		.r_id    (s_r_id)
	);

	// Last flag is only meaningful while beats are offered
	assign s_r_last = s_r_valid & last;

endmodule

`default_nettype wire

//--- hw/read_arbiter.sv
// Two-master AXI4 read arbiter; one burst in flight at a time, ID top bit selects the owner
`timescale 1ns/100ps
`default_nettype none

module read_arbiter import coreinfo_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_n,

	input  logic    m0_ar_valid,
	output logic    m0_ar_ready,
	input  mst_id_t m0_ar_id,
	input  addr_t   m0_ar_addr,
	input  len_t    m0_ar_len,
	output logic    m0_r_valid,
	input  logic    m0_r_ready,
	output data_t   m0_r_data,
	output mst_id_t m0_r_id,
	output logic    m0_r_last,

	input  logic    m1_ar_valid,
	output logic    m1_ar_ready,
	input  mst_id_t m1_ar_id,
	input  addr_t   m1_ar_addr,
	input  len_t    m1_ar_len,
	output logic    m1_r_valid,
	input  logic    m1_r_ready,
	output data_t   m1_r_data,
	output mst_id_t m1_r_id,
	output logic    m1_r_last,

	output logic    s_ar_valid,
	input  logic    s_ar_ready,
	output slv_id_t s_ar_id,
	output addr_t   s_ar_addr,
	output len_t    s_ar_len,
	input  logic    s_r_valid,
	output logic    s_r_ready,
	input  data_t   s_r_data,
	input  slv_id_t s_r_id,
	input  logic    s_r_last
);

	logic locked;      // Burst in flight
	logic last_served; // Master granted most recently
	logic grant_idx;
	logic owner;
	logic ar_fire;
	logic r_done;

	// Round robin only matters when both ask
	always_comb begin
		if (m0_ar_valid && m1_ar_valid) begin
			grant_idx = ~last_served;
		end else begin
			grant_idx = m1_ar_valid;
		end
	end

	assign s_ar_valid = ~locked & (m0_ar_valid | m1_ar_valid);
	assign s_ar_id    = grant_idx ? {1'b1, m1_ar_id} : {1'b0, m0_ar_id}; // Prefix master index
	assign s_ar_addr  = grant_idx ? m1_ar_addr : m0_ar_addr;
	assign s_ar_len   = grant_idx ? m1_ar_len : m0_ar_len;

	assign m0_ar_ready = ~locked & s_ar_ready & m0_ar_valid & ~grant_idx;
	assign m1_ar_ready = ~locked & s_ar_ready & m1_ar_valid & grant_idx;

	assign ar_fire = s_ar_valid & s_ar_ready;
	assign r_done  = s_r_valid & s_r_ready & s_r_last;

	// Response goes back to the master named in the ID
	assign owner = s_r_id[$bits(slv_id_t)-1];

	assign m0_r_valid = s_r_valid & ~owner;
	assign m1_r_valid = s_r_valid & owner;
	assign s_r_ready  = owner ? m1_r_ready : m0_r_ready;

	assign m0_r_data = s_r_data;
	assign m1_r_data = s_r_data;
	assign m0_r_id   = s_r_id[$bits(mst_id_t)-1:0]; // Strip prefix
	assign m1_r_id   = s_r_id[$bits(mst_id_t)-1:0];
	assign m0_r_last = s_r_last;
	assign m1_r_last = s_r_last;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			locked      <= 1'b0;
			last_served <= 1'b1; // So m0 wins the first tie
		end else begin
			if (ar_fire) begin
				locked      <= 1'b1;
				last_served <= grant_idx;
			end else if (r_done) begin
				locked <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/coreinfo_subsys.sv
// Two cores sharing one read-only core-information slave; reads only, one burst at a time
`timescale 1ns/100ps
`default_nettype none

module coreinfo_subsys import coreinfo_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_n,

	input  logic    m0_ar_valid,
	output logic    m0_ar_ready,
	input  mst_id_t m0_ar_id,
	input  addr_t   m0_ar_addr,
	input  len_t    m0_ar_len,
	output logic    m0_r_valid,
	input  logic    m0_r_ready,
	output data_t   m0_r_data,
	output mst_id_t m0_r_id,
	output logic    m0_r_last,

	input  logic    m1_ar_valid,
	output logic    m1_ar_ready,
	input  mst_id_t m1_ar_id,
	input  addr_t   m1_ar_addr,
	input  len_t    m1_ar_len,
	output logic    m1_r_valid,
	input  logic    m1_r_ready,
	output data_t   m1_r_data,
	output mst_id_t m1_r_id,
	output logic    m1_r_last
);

	// Merged slave port
	logic    s_ar_valid;
	logic    s_ar_ready;
	slv_id_t s_ar_id;
	addr_t   s_ar_addr;
	len_t    s_ar_len;
	logic    s_r_valid;
	logic    s_r_ready;
	data_t   s_r_data;
	slv_id_t s_r_id;
	logic    s_r_last;

	read_arbiter u_read_arbiter (
		.clk_i       (clk_i),
		.rst_n       (rst_n),
		.m0_ar_valid (m0_ar_valid),
		.m0_ar_ready (m0_ar_ready),
		.m0_ar_id    (m0_ar_id),
		.m0_ar_addr  (m0_ar_addr),
		.m0_ar_len   (m0_ar_len),
		.m0_r_valid  (m0_r_valid),
		.m0_r_ready  (m0_r_ready),
		.m0_r_data   (m0_r_data),
		.m0_r_id     (m0_r_id),
		.m0_r_last   (m0_r_last),
		.m1_ar_valid (m1_ar_valid),
		.m1_ar_ready (m1_ar_ready),
		.m1_ar_id    (m1_ar_id),
		.m1_ar_addr  (m1_ar_addr),
		.m1_ar_len   (m1_ar_len),
		.m1_r_valid  (m1_r_valid),
		.m1_r_ready  (m1_r_ready),
		.m1_r_data   (m1_r_data),
		.m1_r_id     (m1_r_id),
		.m1_r_last   (m1_r_last),
		.s_ar_valid  (s_ar_valid),
		.s_ar_ready  (s_ar_ready),
		.s_ar_id     (s_ar_id),
		.s_ar_addr   (s_ar_addr),
		.s_ar_len    (s_ar_len),
		.s_r_valid   (s_r_valid),
		.s_r_ready   (s_r_ready),
		.s_r_data    (s_r_data),
		.s_r_id      (s_r_id),
		.s_r_last    (s_r_last)
	);

	coreinfo_slave u_coreinfo_slave (
		.clk_i      (clk_i),
		.rst_n      (rst_n),
		.s_ar_valid (s_ar_valid),
		.s_ar_ready (s_ar_ready),
		.s_ar_id    (s_ar_id),
		.s_ar_addr  (s_ar_addr),
		.s_ar_len   (s_ar_len),
		.s_r_valid  (s_r_valid),
		.s_r_ready  (s_r_ready),
		.s_r_data   (s_r_data),
		.s_r_id     (s_r_id),
		.s_r_last   (s_r_last)
	);

endmodule

`default_nettype wire

//--- tests/tb_coreinfo_subsys.sv
// Random start words stay at 0 to 5 and each master keeps at most one burst in flight
`timescale 1ns/100ps
`default_nettype none

`include "coreinfo_consts.svh"

module tb_coreinfo_subsys import coreinfo_pkg::*; ();

	localparam int CLK_PERIOD       = 10;
	localparam int RAND_REQS        = 16;
	localparam int TOTAL_REQS       = 11 + 2 * RAND_REQS;
	localparam int MAX_BURST_CYCLES = 200; // Gap, setup, 16 stalled beats and the other master

	typedef struct packed {
		mst_id_t id;
		word_t   word;
		len_t    len;
	} req_t;

	logic        clk_i = 1'b0;
	logic        rst_n;
	logic [1:0]  ar_valid;
	logic [1:0]  ar_ready;
	mst_id_t     ar_id [2];
	addr_t       ar_addr [2];
	len_t        ar_len [2];
	logic [1:0]  r_valid;
	logic [1:0]  r_ready;
	data_t       r_data [2];
	mst_id_t     r_id [2];
	logic [1:0]  r_last;

	// Reference model state
	req_t        pend_q [2][$];
	int          beat_cnt [2];
	data_t       exp_data [2];
	mst_id_t     exp_id [2];
	logic [1:0]  exp_last;
	logic [1:0]  exp_busy;
	logic        last_grant;

	string       test_name;
	logic [31:0] lfsr_state = 32'h23a92824;
	int          req_word [2][RAND_REQS];
	int          req_gap [2][RAND_REQS];
	len_t        req_len [2][RAND_REQS];
	logic [31:0] req_ready [2][RAND_REQS];

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	coreinfo_subsys u_coreinfo_subsys (
		.clk_i       (clk_i),
		.rst_n       (rst_n),
		.m0_ar_valid (ar_valid[0]),
		.m0_ar_ready (ar_ready[0]),
		.m0_ar_id    (ar_id[0]),
		.m0_ar_addr  (ar_addr[0]),
		.m0_ar_len   (ar_len[0]),
		.m0_r_valid  (r_valid[0]),
		.m0_r_ready  (r_ready[0]),
		.m0_r_data   (r_data[0]),
		.m0_r_id     (r_id[0]),
		.m0_r_last   (r_last[0]),
		.m1_ar_valid (ar_valid[1]),
		.m1_ar_ready (ar_ready[1]),
		.m1_ar_id    (ar_id[1]),
		.m1_ar_addr  (ar_addr[1]),
		.m1_ar_len   (ar_len[1]),
		.m1_r_valid  (r_valid[1]),
		.m1_r_ready  (r_ready[1]),
		.m1_r_data   (r_data[1]),
		.m1_r_id     (r_id[1]),
		.m1_r_last   (r_last[1])
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		stop_with_failure($sformatf("MISMATCH test=%s %s expected=%h actual=%h",
			test_name, what, expected, actual));
	endtask

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value      = {value[30:0], fb};
		end
		return value;
	endfunction

	// Expected word from the register map
	function automatic data_t map_word(input int m, input int word);
		case (word)
			0:       return (m == 1) ? `CORE1_ID : `CORE0_ID;
			1:       return data_t'(`N_CORES);
			2:       return `COREINFO_VERSION;
			default: return '1;
		endcase
	endfunction

	// Called 1 ns after a rising edge and returns 1 ns after the address transfer edge
	task automatic send_address(input int m, input mst_id_t id, input int word,
		input len_t len);
		logic took;
		ar_valid[m] = 1'b1;
		ar_id[m]    = id;
		ar_addr[m]  = addr_t'(word) << 2;
		ar_len[m]   = len;
		do begin
			@(negedge clk_i);
			took = ar_ready[m];
			@(posedge clk_i);
			#1;
		end while (!took);
		ar_valid[m] = 1'b0;
	endtask

	// Called 1 ns after a rising edge and returns 1 ns after the last-beat edge
	task automatic run_read(input int m, input mst_id_t id, input int word, input len_t len,
		input logic [31:0] ready_pat);
		logic       done;
		logic [4:0] k;
		send_address(m, id, word, len);
		k = '0;
		do begin
			r_ready[m] = ready_pat[k]; // Zero bits stall the data channel
			k          = k + 5'd1;
			@(negedge clk_i);
			done = r_valid[m] & r_ready[m] & r_last[m];
			@(posedge clk_i);
			#1;
		end while (!done);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_i);
			#1;
		end
	endtask

	task automatic drive_random(input int m);
		for (int i = 0; i < RAND_REQS; i++) begin
			idle_cycles(req_gap[m][i]);
			run_read(m, mst_id_t'(i), req_word[m][i], req_len[m][i], req_ready[m][i]);
		end
	endtask

	// Both masters ask for word 0 in the same cycle
	task automatic read_word0_tied();
		fork
			run_read(0, 4'h3, 0, 4'd0, '1);
			run_read(1, 4'h5, 0, 4'd0, '1);
		join
	endtask

	// m0 is served last and its first beat is held by a stall when reset hits
	task automatic reset_during_burst();
		r_ready[0] = 1'b0;
		send_address(0, 4'hB, 0, 4'd3);
		idle_cycles(3);
		rst_n = 1'b0;
		idle_cycles(3);
		rst_n = 1'b1;
	endtask

	// Tracks accepted requests and sets up the expectation for the next beat
	always @(posedge clk_i) begin
		if (!rst_n) begin
			last_grant <= 1'b1; // m0 wins the first tie
			exp_busy   <= '0;
			for (int m = 0; m < 2; m++) begin
				pend_q[m].delete();
				beat_cnt[m] = 0;
			end
		end else begin
			for (int m = 0; m < 2; m++) begin
				if (r_valid[m] && r_ready[m]) begin
					if (r_last[m]) begin
						void'(pend_q[m].pop_front());
						beat_cnt[m] = 0;
					end else begin
						beat_cnt[m] = beat_cnt[m] + 1;
					end
				end
				if (ar_valid[m] && ar_ready[m]) begin
					pend_q[m].push_back('{id: ar_id[m], word: ar_addr[m][11:2], len: ar_len[m]});
					last_grant <= (m == 1);
				end
				if (pend_q[m].size() > 0) begin
					exp_data[m] <= map_word(m, int'(pend_q[m][0].word) + beat_cnt[m]);
					exp_id[m]   <= pend_q[m][0].id;
					exp_last[m] <= (beat_cnt[m] == int'(pend_q[m][0].len));
				end
				exp_busy[m] <= (pend_q[m].size() > 0);
			end
		end
	end

	for (genvar m = 0; m < 2; m++) begin : g_check
		a_data: assert property (@(posedge clk_i) disable iff (!rst_n)
			r_valid[m] |-> r_data[m] == exp_data[m])
			else report_mismatch($sformatf("m%0d r_data", m), exp_data[m], r_data[m]);
		a_id: assert property (@(posedge clk_i) disable iff (!rst_n)
			r_valid[m] |-> r_id[m] == exp_id[m])
			else report_mismatch($sformatf("m%0d r_id", m), 32'(exp_id[m]), 32'(r_id[m]));
		a_last: assert property (@(posedge clk_i) disable iff (!rst_n)
			r_valid[m] |-> r_last[m] == exp_last[m])
			else report_mismatch($sformatf("m%0d r_last", m), 32'(exp_last[m]),
				32'(r_last[m]));
		a_owner: assert property (@(posedge clk_i) disable iff (!rst_n)
			r_valid[m] |-> exp_busy[m])
			else stop_with_failure($sformatf("Response at m%0d with no request pending", m));
		a_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
			$past(r_valid[m] && !r_ready[m]) |-> r_valid[m] && r_data[m] == $past(r_data[m])
			&& r_id[m] == $past(r_id[m]) && r_last[m] == $past(r_last[m]))
			else stop_with_failure($sformatf("Data channel at m%0d changed while stalled", m));
		a_first: assert property (@(posedge clk_i) disable iff (!rst_n)
			(r_valid[m] && !$past(r_valid[m])) |-> $past(ar_valid[m] && ar_ready[m], 2))
			else stop_with_failure($sformatf("First beat at m%0d not two cycles after address",
				m));
		a_next: assert property (@(posedge clk_i) disable iff (!rst_n)
			$past(r_valid[m] && r_ready[m] && !r_last[m]) |-> r_valid[m])
			else stop_with_failure($sformatf("Burst at m%0d stopped before its last beat", m));
		a_ready_valid: assert property (@(posedge clk_i) disable iff (!rst_n)
			ar_ready[m] |-> ar_valid[m])
			else stop_with_failure($sformatf("ar_ready at m%0d high without a request", m));
	end

	a_reset_idle: assert property (@(posedge clk_i) !rst_n |=> (r_valid == 2'b00))
		else stop_with_failure("r_valid high right after reset");
	a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n)
		!(ar_ready[0] && ar_ready[1]))
		else stop_with_failure("Both masters granted at once");
	a_locked: assert property (@(posedge clk_i) disable iff (!rst_n)
		(exp_busy != 2'b00) |-> (ar_ready == 2'b00))
		else stop_with_failure("ar_ready high while a burst is in flight");
	a_round_robin: assert property (@(posedge clk_i) disable iff (!rst_n)
		(ar_valid == 2'b11 && ar_ready != 2'b00) |-> ar_ready[1] == !last_grant)
		else report_mismatch("grant", 32'(!last_grant), 32'(ar_ready[1]));
	a_one_response: assert property (@(posedge clk_i) disable iff (!rst_n)
		!(r_valid[0] && r_valid[1]))
		else stop_with_failure("Response routed to both masters");

	initial begin
		#(TOTAL_REQS * MAX_BURST_CYCLES * CLK_PERIOD);
		stop_with_failure("Timeout: the read traffic did not finish");
	end

	initial begin
		rst_n     = 1'b0;
		ar_valid  = '0;
		r_ready   = '0;
		test_name = "reset";
		for (int m = 0; m < 2; m++) begin
			ar_id[m]   = '0;
			ar_addr[m] = '0;
			ar_len[m]  = '0;
			for (int i = 0; i < RAND_REQS; i++) begin
				req_gap[m][i]   = random_bits(2);
				req_word[m][i]  = random_bits(3) % 6; // Words 3 to 5 read as all ones
				req_len[m][i]   = len_t'(random_bits(4));
				req_ready[m][i] = ~(random_bits(32) & random_bits(32));
			end
		end
		repeat (3) @(posedge clk_i);
		#1;
		rst_n = 1'b1;

		test_name = "tie_after_reset";
		read_word0_tied();

		test_name = "single_beat_map";
		run_read(0, 4'h1, 1, 4'd0, '1);
		run_read(1, 4'h2, 2, 4'd0, '1);
		run_read(0, 4'h4, 7, 4'd0, '1);
		run_read(1, 4'h6, 7, 4'd0, '1);

		test_name = "burst_steps";
		run_read(1, 4'h9, 0, 4'd15, '1);
		run_read(0, 4'hA, 3, 4'd2, 32'h5555_5555);

		test_name = "random_traffic";
		fork
			drive_random(0);
			drive_random(1);
		join

		test_name = "reset_mid_burst";
		reset_during_burst();

		test_name = "tie_after_second_reset";
		read_word0_tied();
		idle_cycles(4);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/coreinfo_pkg.sv
coreinfo/beat_counter.sv
coreinfo/read_fsm.sv
coreinfo/info_regs.sv
coreinfo/coreinfo_slave.sv
hw/read_arbiter.sv
hw/coreinfo_subsys.sv
tests/tb_coreinfo_subsys.sv

//--- Makefile
# Verilator build and run of the core-information testbench

SIM := obj_dir/Vtb_coreinfo_subsys

.PHONY: all run clean

all: run

$(SIM): flist.f common/coreinfo_consts.svh common/*.sv hw/*.sv coreinfo/*.sv tests/*.sv
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_coreinfo_subsys -f flist.f

# Pass only when the simulation prints the pass message
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
